// File: logic/la_pkg.sv
`default_nettype none

package la_pkg;

  // channel count of the analyzer
  localparam int CHLS = 32;

  typedef logic [CHLS-1:0] smpl_t; // one snapshot, also the host word
  typedef logic [23:0]     div_t;  // clock division factor

  // host command opcodes
  typedef enum logic [1:0] {
    OP_SET_DIV   = 2'd0,
    OP_SET_MASK  = 2'd1,
    OP_SET_VALUE = 2'd2,
    OP_ARM       = 2'd3
  } op_t;

  localparam int CAPTURE_LEN = 24;     // samples per trigger
  typedef logic [4:0] cnt_t;           // holds 0 .. CAPTURE_LEN

  localparam int FIFO_DEPTH = 16;      // power of two, pointers wrap
  typedef logic [3:0] fifo_ptr_t;

  localparam int MAX_CREDITS = 4;      // receiver buffer slots
  typedef logic [2:0] credit_t;        // holds 0 .. MAX_CREDITS

endpackage

`default_nettype wire

// File: logic/cmd_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module cmd_decoder (
  input  logic            clk_i,
  input  logic            rst_in,       // sync, active low
  input  logic            cmd_valid_i,  // one command per high cycle
  input  la_pkg::op_t     cmd_op_i,
  input  la_pkg::smpl_t   cmd_data_i,
  output logic            set_div_o,    // command was OP_SET_DIV
  output logic            exec_o,       // one pulse per command
  output logic            arm_o,        // one pulse on OP_ARM
  output la_pkg::div_t    fdiv_o,
  output la_pkg::smpl_t   trig_mask_o,
  output la_pkg::smpl_t   trig_value_o
);

  // opcode strobes for the current command
  logic is_div;
  logic is_mask;
  logic is_value;
  logic is_arm;

  assign is_div   = cmd_valid_i && (cmd_op_i == la_pkg::OP_SET_DIV);
  assign is_mask  = cmd_valid_i && (cmd_op_i == la_pkg::OP_SET_MASK);
  assign is_value = cmd_valid_i && (cmd_op_i == la_pkg::OP_SET_VALUE);
  assign is_arm   = cmd_valid_i && (cmd_op_i == la_pkg::OP_ARM);

  // flag pair and arm pulse
  always_ff @(posedge clk_i) begin : flags
    if (!rst_in) begin
      set_div_o <= 1'b0;
      exec_o    <= 1'b0;
      arm_o     <= 1'b0;
    end else begin
      set_div_o <= is_div;
      exec_o    <= cmd_valid_i; // every command executes
      arm_o     <= is_arm;
    end
  end

  // divider payload, only used when set_div_o is high
  always_ff @(posedge clk_i) begin : div_payload
    if (cmd_valid_i) begin
      fdiv_o <= cmd_data_i[23:0]; // low 24 bits carry the factor
    end
  end

  // trigger configuration holds until overwritten
  always_ff @(posedge clk_i) begin : trig_cfg
    if (!rst_in) begin
      trig_mask_o  <= '0; // zero mask matches anything
      trig_value_o <= '0;
    end else begin
      if (is_mask)  trig_mask_o  <= cmd_data_i;
      if (is_value) trig_value_o <= cmd_data_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/sampler.sv
`default_nettype none
`timescale 1ns/1ps

module sampler (
  input  logic          clk_i,
  input  logic          rst_in,
  input  la_pkg::div_t  fdiv_i,     // new division factor
  input  logic          set_div_i,  // command carries a divider
  input  logic          exec_i,     // command strobe
  input  la_pkg::smpl_t data_i,     // live channels
  output la_pkg::smpl_t smpls_o,    // last snapshot
  output logic          stb_o       // snapshot taken this cycle
);

  la_pkg::div_t  div_q;   // stored factor
  la_pkg::div_t  cnt_q;   // free running divider count
  la_pkg::smpl_t smpl_q;

  assign smpls_o = smpl_q;

  // divide clock and grab channels on wrap
  always_ff @(posedge clk_i) begin : take_samples
    if (!rst_in) begin
      cnt_q <= '0;
      stb_o <= 1'b0;
    end else if (cnt_q < div_q) begin
      cnt_q <= cnt_q + 1'b1;
      stb_o <= 1'b0;
    end else begin
      cnt_q <= '0;     // wrap, also catches a shrunk divider
      stb_o <= 1'b1;
    end
  end

  // snapshot register, same wrap condition
  always_ff @(posedge clk_i) begin : snapshot
    if (cnt_q >= div_q) begin
      smpl_q <= data_i;
    end
  end

  // divider update from the decoder
  always_ff @(posedge clk_i) begin : set_fdiv
    if (!rst_in) begin
      div_q <= '0; // stb every cycle after reset
    end else if (set_div_i && exec_i) begin
      div_q <= fdiv_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/trigger_unit.sv
`default_nettype none
`timescale 1ns/1ps

module trigger_unit (
  input  logic          clk_i,
  input  logic          rst_in,
  input  logic          arm_i,         // one cycle arm request
  input  la_pkg::smpl_t trig_mask_i,   // bits that take part in match
  input  la_pkg::smpl_t trig_value_i,  // required level of those bits
  input  la_pkg::smpl_t smpls_i,
  input  logic          stb_i,         // new sample on smpls_i
  output logic          wr_en_o,       // push into FIFO
  output la_pkg::smpl_t wr_data_o,
  output logic          clear_ovf_o,   // new capture clears overflow
  output logic          armed_o
);

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    CAPTURE
  } state_t;

  state_t       state_q;
  la_pkg::cnt_t cnt_q;   // samples pushed so far
  logic         match;
  logic         last;

  // masked compare, zero mask always matches
  assign match = ((smpls_i ^ trig_value_i) & trig_mask_i) == '0;
  assign last  = (cnt_q == la_pkg::cnt_t'(la_pkg::CAPTURE_LEN - 1));

  assign armed_o = (state_q != IDLE);

  always_ff @(posedge clk_i) begin : fsm
    if (!rst_in) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      wr_en_o     <= 1'b0;
      clear_ovf_o <= 1'b0;
    end else begin
      wr_en_o     <= 1'b0;
      clear_ovf_o <= 1'b0;
      case (state_q)
        IDLE, ARMED: begin
          if (arm_i) begin
            state_q     <= ARMED;  // re-arm just restarts the wait
            clear_ovf_o <= 1'b1;
          end else if (state_q == ARMED && stb_i && match) begin
            wr_en_o <= 1'b1;       // trigger sample is the first push
            cnt_q   <= 5'd1;
            state_q <= CAPTURE;
          end
        end
        CAPTURE: begin             // arm is ignored here
          if (stb_i) begin
            wr_en_o <= 1'b1;
            cnt_q   <= cnt_q + 1'b1;
            if (last) state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // payload follows stb, valid only with wr_en_o
  always_ff @(posedge clk_i) begin : push_data
    if (stb_i) begin
      wr_data_o <= smpls_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/sample_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module sample_fifo (
  input  logic          clk_i,
  input  logic          rst_in,
  input  logic          wr_en_i,
  input  la_pkg::smpl_t wr_data_i,
  input  logic          rd_en_i,      // pop head, rd_data_o valid now
  input  logic          clear_ovf_i,
  output la_pkg::smpl_t rd_data_o,    // show-ahead head word
  output logic          empty_o,
  output logic          ovf_o         // sticky, a write was dropped
);

  la_pkg::smpl_t mem [la_pkg::FIFO_DEPTH];

  la_pkg::fifo_ptr_t wr_ptr_q;
  la_pkg::fifo_ptr_t rd_ptr_q;
  logic [$clog2(la_pkg::FIFO_DEPTH):0] fill_q; // one extra bit for full

  logic full;
  logic do_wr;
  logic do_rd;

  assign full    = (fill_q == la_pkg::FIFO_DEPTH);
  assign empty_o = (fill_q == '0);
  assign do_wr   = wr_en_i && !full;   // no write on full, even with a pop
  assign do_rd   = rd_en_i && !empty_o;

  assign rd_data_o = mem[rd_ptr_q];

  // storage only, no reset
  always_ff @(posedge clk_i) begin : store
    if (do_wr) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin : ptrs
    if (!rst_in) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
      if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;          // both or neither
      endcase
    end
  end

  // dropped write sets it, next arm clears it
  always_ff @(posedge clk_i) begin : overflow
    if (!rst_in) begin
      ovf_o <= 1'b0;
    end else if (wr_en_i && full) begin
      ovf_o <= 1'b1;
    end else if (clear_ovf_i) begin
      ovf_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/credit_tx.sv
`default_nettype none
`timescale 1ns/1ps

module credit_tx (
  input  logic          clk_i,
  input  logic          rst_in,
  input  logic          empty_i,
  input  la_pkg::smpl_t rd_data_i,    // FIFO head
  input  logic          credit_i,     // one credit back per high cycle
  output logic          rd_en_o,      // pop request
  output logic          out_valid_o,
  output la_pkg::smpl_t out_data_o
);

  la_pkg::credit_t credits_q; // free slots at the receiver

  // pop whenever data and a credit are both there
  assign rd_en_o = !empty_i && (credits_q != '0);

  always_ff @(posedge clk_i) begin : credit_cnt
    if (!rst_in) begin
      credits_q <= la_pkg::credit_t'(la_pkg::MAX_CREDITS);
    end else begin
      case ({rd_en_o, credit_i})
        2'b10:   credits_q <= credits_q - 1'b1; // word sent
        2'b01:   credits_q <= credits_q + 1'b1; // slot freed
        default: credits_q <= credits_q;        // net zero
      endcase
    end
  end

  // one cycle valid after each pop
  always_ff @(posedge clk_i) begin : out_valid
    if (!rst_in) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= rd_en_o;
    end
  end

  always_ff @(posedge clk_i) begin : out_word
    if (rd_en_o) begin
      out_data_o <= rd_data_i; // held until next pop
    end
  end

endmodule

`default_nettype wire

// File: logic/la_top.sv
`default_nettype none
`timescale 1ns/1ps

module la_top (
  input  logic          clk_i,
  input  logic          rst_in,
  input  logic          cmd_valid_i,
  input  la_pkg::op_t   cmd_op_i,
  input  la_pkg::smpl_t cmd_data_i,
  input  la_pkg::smpl_t data_i,       // probed channels
  input  logic          credit_i,
  output logic          out_valid_o,
  output la_pkg::smpl_t out_data_o,
  output logic          armed_o,
  output logic          ovf_o
);

  // decoder outputs
  logic          set_div;
  logic          exec;
  logic          arm;
  la_pkg::div_t  fdiv;
  la_pkg::smpl_t trig_mask;
  la_pkg::smpl_t trig_value;

  // sampler to trigger
  la_pkg::smpl_t smpls;
  logic          stb;

  // trigger to FIFO
  logic          wr_en;
  la_pkg::smpl_t wr_data;
  logic          clear_ovf;

  // FIFO to output stage
  la_pkg::smpl_t rd_data;
  logic          empty;
  logic          rd_en;

  cmd_decoder u_cmd_decoder (
    .clk_i        (clk_i),
    .rst_in       (rst_in),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_data_i   (cmd_data_i),
    .set_div_o    (set_div),
    .exec_o       (exec),
    .arm_o        (arm),
    .fdiv_o       (fdiv),
    .trig_mask_o  (trig_mask),
    .trig_value_o (trig_value)
  );

  sampler u_sampler (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .fdiv_i    (fdiv),
    .set_div_i (set_div),
    .exec_i    (exec),
    .data_i    (data_i),
    .smpls_o   (smpls),
    .stb_o     (stb)
  );

  trigger_unit u_trigger_unit (
    .clk_i        (clk_i),
    .rst_in       (rst_in),
    .arm_i        (arm),
    .trig_mask_i  (trig_mask),
    .trig_value_i (trig_value),
    .smpls_i      (smpls),
    .stb_i        (stb),
    .wr_en_o      (wr_en),
    .wr_data_o    (wr_data),
    .clear_ovf_o  (clear_ovf),
    .armed_o      (armed_o)
  );

  // no back-pressure upstream, full FIFO drops
  sample_fifo u_sample_fifo (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .wr_en_i     (wr_en),
    .wr_data_i   (wr_data),
    .rd_en_i     (rd_en),
    .clear_ovf_i (clear_ovf),
    .rd_data_o   (rd_data),
    .empty_o     (empty),
    .ovf_o       (ovf_o)
  );

  credit_tx u_credit_tx (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .empty_i     (empty),
    .rd_data_i   (rd_data),
    .credit_i    (credit_i),
    .rd_en_o     (rd_en),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

endmodule

`default_nettype wire

// File: dv/la_clkgen.sv
`default_nettype none
`timescale 1ns/1ps

module la_clkgen (
  output logic clk_o,   // 10 ns period
  output logic rst_no   // active low, sync to clk_o
);

  initial begin : clock
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // hold reset over 10 rising edges, release on a falling edge
  initial begin : reset
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/la_tb.sv
`default_nettype none
`timescale 1ns/1ps

module la_tb;

  localparam int TIMEOUT = 8000; // cycle limit well above the full run

  logic          clk_i;
  logic          rst_in;
  logic          cmd_valid_i;
  la_pkg::op_t   cmd_op_i;
  la_pkg::smpl_t cmd_data_i;
  la_pkg::smpl_t data_i;       // counter whose value tells when it was sampled
  logic          credit_i;
  logic          out_valid_o;
  la_pkg::smpl_t out_data_o;
  logic          armed_o;
  logic          ovf_o;

  la_pkg::smpl_t got [$];      // words seen at the host
  int            errors = 0;
  int            cycles = 0;
  int            owed   = 0;   // credits held by the host
  int            grant  = 0;   // single returns allowed while ret_en is low
  bit            ret_en = 1'b1; // host returns credits at once

  la_clkgen u_clkgen (.clk_o(clk_i), .rst_no(rst_in));

  la_top UUT (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .data_i      (data_i),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .armed_o     (armed_o),
    .ovf_o       (ovf_o)
  );

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("errors: %0d", errors);
      $display("Finished with errors");
      $finish;
    end
  end

  // collect host side at negedge then drive next inputs
  task automatic step();
    @(negedge clk_i);
    if (out_valid_o === 1'b1) begin
      got.push_back(out_data_o);
      owed++;                      // receiver slot now in use
    end
    data_i      = data_i + 1'b1;
    cmd_valid_i = 1'b0;
    credit_i    = 1'b0;
    if (owed > 0 && (ret_en || grant > 0)) begin
      credit_i = 1'b1;
      owed--;
      if (!ret_en) grant--;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic send_cmd(input la_pkg::op_t op, input la_pkg::smpl_t dat);
    step();
    cmd_valid_i = 1'b1;            // taken at the next rising edge
    cmd_op_i    = op;
    cmd_data_i  = dat;
  endtask

  task automatic wait_words(input int n);
    int guard;
    guard = 0;
    while (got.size() < n && guard < 1000) begin
      step();
      guard++;
    end
    if (got.size() < n) begin
      errors++;
      $display("at %0t only %0d of %0d words arrived", $time, got.size(), n);
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, act, exp);
    end
  endtask

  // consecutive words differ by div+1 unless gaps are allowed
  task automatic check_order(input int stepv, input bit exact);
    la_pkg::smpl_t diff;
    for (int i = 1; i < got.size(); i++) begin
      diff = got[i] - got[i-1];
      if (exact && diff != stepv) begin
        errors++;
        $display("Mismatch at %0t: out_data_o word %0d got %0h expected %0h",
                 $time, i, got[i], got[i-1] + stepv);
      end else if (!exact && (diff == 0 || diff > 1000 || diff % stepv != 0)) begin
        errors++;
        $display("word %0d (%0h) out of order or off spacing after %0h",
                 i, got[i], got[i-1]);
      end
    end
  endtask

  task automatic arm_capture(input int div, input la_pkg::smpl_t mask,
                             input la_pkg::smpl_t value);
    got.delete();
    send_cmd(la_pkg::OP_SET_DIV, la_pkg::smpl_t'(div));
    send_cmd(la_pkg::OP_SET_MASK, mask);
    send_cmd(la_pkg::OP_SET_VALUE, value);
    send_cmd(la_pkg::OP_ARM, '0);
  endtask

  task automatic reset_test();
    repeat (40) begin // 10 cycles in reset then quiet without an arm
      step();
      compare_value("out_valid_o", out_valid_o, 1'b0);
      compare_value("armed_o", armed_o, 1'b0);
      compare_value("ovf_o", ovf_o, 1'b0);
    end
    compare_value("out_valid_o word count", got.size(), 0);
  endtask

  task automatic divider_test(input int div);
    ret_en = 1'b1;
    arm_capture(div, '0, '0);      // zero mask so the first sample triggers
    wait_words(la_pkg::CAPTURE_LEN);
    idle(30);                      // nothing extra may follow
    compare_value("out_valid_o word count", got.size(), la_pkg::CAPTURE_LEN);
    check_order(div + 1, 1'b1);
    compare_value("armed_o", armed_o, 1'b0);
  endtask

  task automatic trigger_test();
    la_pkg::smpl_t first;
    int            guard;
    ret_en = 1'b1;
    first  = data_i + 32'd100;     // well past the arm and within one byte wrap
    arm_capture(0, 32'h0000_00ff, {24'h0, first[7:0]});
    idle(2);                       // arm through decoder and trigger
    guard = 0;
    while (got.size() == 0 && guard < 300) begin
      compare_value("armed_o", armed_o, 1'b1);
      step();
      guard++;
    end
    wait_words(la_pkg::CAPTURE_LEN);
    idle(30);
    compare_value("out_valid_o word count", got.size(), la_pkg::CAPTURE_LEN);
    if (got.size() > 0) begin
      compare_value("out_data_o first word", got[0], first);
    end
    check_order(1, 1'b1);
    compare_value("armed_o", armed_o, 1'b0);
  endtask

  task automatic credit_test();
    int n;
    ret_en = 1'b0;                 // host keeps every credit
    arm_capture(0, '0, '0);
    wait_words(la_pkg::MAX_CREDITS);
    idle(50);
    compare_value("out_valid_o word count", got.size(), la_pkg::MAX_CREDITS);
    // fifo kept the first FIFO_DEPTH pushes behind the credited ones
    for (n = la_pkg::MAX_CREDITS; n < la_pkg::MAX_CREDITS + la_pkg::FIFO_DEPTH; n++) begin
      grant = 1;
      wait_words(n + 1);
      idle(8);                     // a credit frees exactly one word
      compare_value("out_valid_o word count", got.size(), n + 1);
    end
    check_order(1, 1'b1);
    ret_en = 1'b1;
    idle(20);                      // give the rest back
  endtask

  task automatic overflow_test();
    int guard;
    ret_en = 1'b0;
    arm_capture(1, '0, '0);
    idle(3);                       // clear pulse reaches the FIFO
    compare_value("ovf_o", ovf_o, 1'b0);
    wait_words(la_pkg::MAX_CREDITS);
    guard = 0;
    while (armed_o === 1'b1 && guard < 500) begin
      step();
      guard++;
    end
    idle(2);                       // last push lands
    compare_value("ovf_o", ovf_o, 1'b1);
    ret_en = 1'b1;
    wait_words(la_pkg::MAX_CREDITS + la_pkg::FIFO_DEPTH);
    idle(30);
    compare_value("out_valid_o word count", got.size(),
                  la_pkg::MAX_CREDITS + la_pkg::FIFO_DEPTH);
    check_order(2, 1'b0);
    compare_value("ovf_o", ovf_o, 1'b1); // sticky until next arm
    arm_capture(0, '0, '0);
    idle(3);
    compare_value("ovf_o", ovf_o, 1'b0);
    wait_words(la_pkg::CAPTURE_LEN);
    idle(30);
    compare_value("ovf_o", ovf_o, 1'b0);
  endtask

  initial begin : run
    cmd_valid_i = 1'b0;
    cmd_op_i    = la_pkg::OP_SET_DIV;
    cmd_data_i  = '0;
    data_i      = '0;
    credit_i    = 1'b0;
    reset_test();
    divider_test(3);
    divider_test(0);
    trigger_test();
    credit_test();
    overflow_test();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/la_pkg.sv
logic/cmd_decoder.sv
logic/sampler.sv
logic/trigger_unit.sv
logic/sample_fifo.sv
logic/credit_tx.sv
logic/la_top.sv
dv/la_clkgen.sv
dv/la_tb.sv
